/* bench/tb_hello_top.sv */
// One OCL access at a time, single beats only; expects the default SYNC_STAGES and reset values
`default_nettype none
`timescale 1ns/1ps

module tb_hello_top;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int DRIVE_DELAY    = 2;
  localparam hello_pkg::cnt_t WMARK = 16'h1234;

  typedef enum {OP_WRITE, OP_READ, OP_LED} op_t;

  logic                 clk_main_a0;
  logic                 rst_main_n_sync;
  logic                 ocl_awvalid;
  hello_pkg::ocl_addr_t ocl_awaddr;
  logic                 ocl_awready;
  logic                 ocl_wvalid;
  hello_pkg::ocl_data_t ocl_wdata;
  logic [3:0]           ocl_wstrb;
  logic                 ocl_wready;
  logic                 ocl_bvalid;
  hello_pkg::ocl_resp_t ocl_bresp;
  logic                 ocl_bready;
  logic                 ocl_arvalid;
  hello_pkg::ocl_addr_t ocl_araddr;
  logic                 ocl_arready;
  logic                 ocl_rvalid;
  hello_pkg::ocl_data_t ocl_rdata;
  hello_pkg::ocl_resp_t ocl_rresp;
  logic                 ocl_rready;
  hello_pkg::led_t      status_vdip;
  hello_pkg::led_t      status_vled;

  int          errors = 0;
  int          timeouts = 0;
  logic [31:0] rng_state = 32'd64;

  // Stimulus table with one entry per step
  op_t                  tbl_op[$];
  hello_pkg::ocl_addr_t tbl_addr[$];
  hello_pkg::ocl_data_t tbl_data[$];
  hello_pkg::ocl_data_t tbl_exp[$];

  hello_top i_dut (.*);

  initial begin
    clk_main_a0 = 1'b0;
    forever #20 clk_main_a0 = ~clk_main_a0;
  end

  // ------------------------------------------------------------
  // Helpers and expected-value rules
  // ------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk_main_a0);
    #(DRIVE_DELAY);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Byte 0 lands in byte 3 and so on
  function automatic hello_pkg::ocl_data_t reverse_bytes(input hello_pkg::ocl_data_t w);
    hello_pkg::ocl_data_t r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  // Count in the low half and the at-or-above flag in bit 16
  function automatic hello_pkg::ocl_data_t status_word(input hello_pkg::cnt_t count,
                                                       input hello_pkg::cnt_t wmark);
    return {15'd0, (count >= wmark), count};
  endfunction

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: waited %0d cycles for %s", $time, TIMEOUT_CYCLES, what);
  endtask

  task automatic check_data(input hello_pkg::ocl_data_t got, input hello_pkg::ocl_data_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_led(input hello_pkg::led_t got, input hello_pkg::led_t exp,
                           input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is 0x%04h, expected 0x%04h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input hello_pkg::ocl_resp_t got, input string what);
    if (got !== hello_pkg::OCL_RESP_OKAY) begin
      errors++;
      $display("Fail at %0t: %s is %0d, expected OKAY", $time, what, got);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ------------------------------------------------------------
  // OCL bus tasks
  // ------------------------------------------------------------
  // Address and data offered together
  task automatic write_request(input hello_pkg::ocl_addr_t addr,
                               input hello_pkg::ocl_data_t data);
    int n;
    ocl_awaddr  = addr;
    ocl_awvalid = 1'b1;
    ocl_wdata   = data;
    ocl_wvalid  = 1'b1;
    n = 0;
    while (!ocl_awready && n < TIMEOUT_CYCLES) begin
      next_cycle();
      n++;
    end
    if (!ocl_awready) report_timeout("awready");
    next_cycle();
    ocl_awvalid = 1'b0;
    n = 0;
    while (!ocl_wready && n < TIMEOUT_CYCLES) begin
      next_cycle();
      n++;
    end
    if (!ocl_wready) report_timeout("wready");
    next_cycle();
    ocl_wvalid = 1'b0;
  endtask

  // Assumes bready already high
  task automatic wait_bresp();
    int n;
    n = 0;
    while (!ocl_bvalid && n < TIMEOUT_CYCLES) begin
      next_cycle();
      n++;
    end
    if (!ocl_bvalid) begin
      report_timeout("bvalid");
    end else begin
      check_resp(ocl_bresp, "bresp");
    end
    next_cycle();
  endtask

  task automatic ocl_write(input hello_pkg::ocl_addr_t addr, input hello_pkg::ocl_data_t data);
    write_request(addr, data);
    wait_bresp();
  endtask

  task automatic ocl_read(input hello_pkg::ocl_addr_t addr, output hello_pkg::ocl_data_t data);
    int n;
    ocl_araddr  = addr;
    ocl_arvalid = 1'b1;
    n = 0;
    while (!ocl_arready && n < TIMEOUT_CYCLES) begin
      next_cycle();
      n++;
    end
    if (!ocl_arready) report_timeout("arready");
    next_cycle();
    ocl_arvalid = 1'b0;
    n = 0;
    while (!ocl_rvalid && n < TIMEOUT_CYCLES) begin
      next_cycle();
      n++;
    end
    if (!ocl_rvalid) report_timeout("rvalid");
    data = ocl_rdata;
    check_resp(ocl_rresp, "rresp");
    next_cycle();
  endtask

  // ------------------------------------------------------------
  // Table and directed sequences
  // ------------------------------------------------------------
  task automatic add_step(input op_t op, input hello_pkg::ocl_addr_t addr,
                          input hello_pkg::ocl_data_t data, input hello_pkg::ocl_data_t exp);
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_data.push_back(data);
    tbl_exp.push_back(exp);
  endtask

  task automatic run_table();
    hello_pkg::ocl_data_t got;
    int n;
    for (int i = 0; i < tbl_op.size(); i++) begin
      case (tbl_op[i])
        OP_WRITE: ocl_write(tbl_addr[i], tbl_data[i]);
        OP_READ: begin
          ocl_read(tbl_addr[i], got);
          check_data(got, tbl_exp[i], $sformatf("read of 0x%03h", tbl_addr[i]));
        end
        // New DIP pattern and a wait for the masked LEDs
        OP_LED: begin
          status_vdip = tbl_data[i][15:0];
          n = 0;
          while (status_vled !== tbl_exp[i][15:0] && n < TIMEOUT_CYCLES) begin
            next_cycle();
            n++;
          end
          check_led(status_vled, tbl_exp[i][15:0], "status_vled");
        end
      endcase
    end
  endtask

  // Tick limit 0 so the count moves every cycle
  task automatic check_saturation();
    hello_pkg::ocl_data_t got;
    int polls;
    ocl_write(hello_pkg::CNT_LOAD_ADDR, 32'h0000_FFF0);
    ocl_write(hello_pkg::CNT_CTRL_ADDR, 32'h0000_0003);
    got = '0;
    polls = 0;
    while (got[15:0] != 16'hFFFF && polls < TIMEOUT_CYCLES) begin
      ocl_read(hello_pkg::CNT_STATUS_ADDR, got);
      polls++;
    end
    if (got[15:0] != 16'hFFFF) report_timeout("count to saturate");
    repeat (20) next_cycle();
    ocl_read(hello_pkg::CNT_STATUS_ADDR, got);
    check_data(got, status_word(16'hFFFF, WMARK), "saturated status");
    ocl_read(hello_pkg::CNT_STATUS_ADDR, got);
    check_data(got, status_word(16'hFFFF, WMARK), "saturated status again");
  endtask

  task automatic check_backpressure(input hello_pkg::ocl_data_t first,
                                    input hello_pkg::ocl_data_t second);
    hello_pkg::ocl_data_t got;
    int n;
    ocl_bready = 1'b0;
    write_request(hello_pkg::HELLO_WORLD_ADDR, first);
    n = 0;
    while (!ocl_bvalid && n < TIMEOUT_CYCLES) begin
      next_cycle();
      n++;
    end
    if (!ocl_bvalid) report_timeout("bvalid under back-pressure");
    // Response stuck and no new address taken
    repeat (5) begin
      check_flag(ocl_bvalid, 1'b1, "bvalid with bready low");
      check_flag(ocl_awready, 1'b0, "awready with bready low");
      next_cycle();
    end
    ocl_bready = 1'b1;
    wait_bresp();
    check_flag(ocl_awready, 1'b1, "awready after response");
    ocl_write(hello_pkg::HELLO_WORLD_ADDR, second);
    // Read response held with rready low
    ocl_rready = 1'b0;
    ocl_read(hello_pkg::HELLO_WORLD_ADDR, got);
    check_data(got, reverse_bytes(second), "hello world after back-pressure");
    // Register rewritten while the read data waits
    ocl_write(hello_pkg::HELLO_WORLD_ADDR, first);
    check_flag(ocl_rvalid, 1'b1, "rvalid with rready low");
    check_data(ocl_rdata, reverse_bytes(second), "rdata with rready low");
    ocl_rready = 1'b1;
    next_cycle();
    check_flag(ocl_rvalid, 1'b0, "rvalid after rready");
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    hello_pkg::ocl_data_t w[4];
    hello_pkg::led_t      p1;
    hello_pkg::led_t      p2;
    rst_main_n_sync = 1'b0;
    ocl_awvalid     = 1'b0;
    ocl_awaddr      = '0;
    ocl_wvalid      = 1'b0;
    ocl_wdata       = '0;
    ocl_wstrb       = 4'hF;
    ocl_bready      = 1'b1;
    ocl_arvalid     = 1'b0;
    ocl_araddr      = '0;
    ocl_rready      = 1'b1;
    status_vdip     = '0;
    repeat (5) @(posedge clk_main_a0);
    #(DRIVE_DELAY);
    check_flag(ocl_bvalid, 1'b0, "bvalid in reset");
    check_flag(ocl_rvalid, 1'b0, "rvalid in reset");
    check_led(status_vled, 16'h0000, "status_vled in reset");
    rst_main_n_sync = 1'b1;
    next_cycle();

    for (int i = 0; i < 4; i++) begin
      rng_state = xorshift32(rng_state);
      w[i] = rng_state;
    end
    p1 = 16'hF0F0;
    p2 = 16'h3C5A;

    // Hello world, LED shadow, unmapped reads
    add_step(OP_WRITE, hello_pkg::HELLO_WORLD_ADDR, w[0], '0);
    add_step(OP_READ, hello_pkg::HELLO_WORLD_ADDR, '0, reverse_bytes(w[0]));
    add_step(OP_READ, hello_pkg::VLED_ADDR, '0, {16'h0000, w[0][15:0]});
    add_step(OP_READ, 32'h0000_0518, '0, hello_pkg::UNIMPLEMENTED_VALUE);
    add_step(OP_READ, 32'h0000_0000, '0, hello_pkg::UNIMPLEMENTED_VALUE);
    add_step(OP_LED, '0, {16'h0000, p1}, {16'h0000, w[0][15:0] & p1});
    add_step(OP_LED, '0, {16'h0000, p2}, {16'h0000, w[0][15:0] & p2});
    add_step(OP_WRITE, hello_pkg::HELLO_WORLD_ADDR, w[1], '0);
    add_step(OP_READ, hello_pkg::HELLO_WORLD_ADDR, '0, reverse_bytes(w[1]));
    add_step(OP_LED, '0, {16'h0000, p2}, {16'h0000, w[1][15:0] & p2});
    // Counter with enable off
    add_step(OP_WRITE, hello_pkg::CNT_CTRL_ADDR, 32'h0000_0000, '0);
    add_step(OP_WRITE, hello_pkg::CNT_WMARK_ADDR, {16'h0000, WMARK}, '0);
    add_step(OP_WRITE, hello_pkg::CNT_LOAD_ADDR, 32'h0000_8000, '0);
    add_step(OP_READ, hello_pkg::CNT_STATUS_ADDR, '0, status_word(16'h8000, WMARK));
    add_step(OP_WRITE, hello_pkg::CNT_LOAD_ADDR, 32'h0000_1000, '0);
    add_step(OP_READ, hello_pkg::CNT_STATUS_ADDR, '0, status_word(16'h1000, WMARK));
    // Clear plus oneshot and tick limit 0x2A
    add_step(OP_WRITE, hello_pkg::CNT_CTRL_ADDR, 32'h0000_2A06, '0);
    add_step(OP_READ, hello_pkg::CNT_STATUS_ADDR, '0, status_word(16'h0000, WMARK));
    add_step(OP_READ, hello_pkg::CNT_CTRL_ADDR, '0, 32'h0000_2A02);

    run_table();
    check_saturation();
    check_backpressure(w[2], w[3]);

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module tb_hello_top -o tb_hello_top

output="$(./obj_dir/tb_hello_top)"
echo "$output"

if grep -qx "Simulation completed successfully" <<< "$output"; then
  exit 0
fi
exit 1

/* src.f */
src/hello_pkg.sv
src/ocl_slave.sv
src/hello_regs.sv
src/tick_counter.sv
src/vled_mask.sv
src/hello_top.sv
bench/tb_hello_top.sv

/* src/hello_pkg.sv */
// Shared widths, OCL register map and FSM encodings; addresses are fixed byte offsets on BAR0
`default_nettype none

package hello_pkg;

  // ------------------------------------------------------------
  // Widths with a meaning of their own
  // ------------------------------------------------------------
  typedef logic [31:0] ocl_addr_t;
  typedef logic [31:0] ocl_data_t;
  typedef logic [1:0]  ocl_resp_t;
  typedef logic [15:0] led_t;
  typedef logic [15:0] cnt_t;
  typedef logic [7:0]  tick_t;

  // One FSM per AXI-Lite direction
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_LOOKUP, RD_RESP} rd_state_t;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------
  localparam ocl_addr_t HELLO_WORLD_ADDR = 32'h0000_0500;
  localparam ocl_addr_t VLED_ADDR        = 32'h0000_0504;
  // Enable bit 0, oneshot bit 1, clear pulse bit 2, tick limit 15:8
  localparam ocl_addr_t CNT_CTRL_ADDR    = 32'h0000_0508;
  localparam ocl_addr_t CNT_LOAD_ADDR    = 32'h0000_050C;
  localparam ocl_addr_t CNT_WMARK_ADDR   = 32'h0000_0510;
  // Read only, count in 15:0 and watermark flag in bit 16
  localparam ocl_addr_t CNT_STATUS_ADDR  = 32'h0000_0514;

  // Returned for every address outside the map
  localparam ocl_data_t UNIMPLEMENTED_VALUE = 32'hDEAD_DEAD;
  localparam ocl_resp_t OCL_RESP_OKAY       = 2'b00;

endpackage

`default_nettype wire

/* src/hello_regs.sv */
// Write-strobe register file; load and watermark are write only, unknown addresses read 0xDEADDEAD
`default_nettype none
`timescale 1ns/1ps

module hello_regs (
  input  wire logic                 clk_main_a0,
  input  wire logic                 rst_main_n_sync,
  input  wire logic                 reg_wr_en,
  input  wire hello_pkg::ocl_addr_t reg_wr_addr,
  input  wire hello_pkg::ocl_data_t reg_wr_data,
  input  wire hello_pkg::ocl_addr_t reg_rd_addr,
  output hello_pkg::ocl_data_t      reg_rd_data,
  output hello_pkg::ocl_data_t      hello_world,
  output logic                      cnt_enable,
  output logic                      cnt_oneshot,
  output hello_pkg::tick_t          tick_limit,
  output logic                      cnt_load,
  output hello_pkg::cnt_t           cnt_load_value,
  output logic                      cnt_clear,
  output hello_pkg::cnt_t           cnt_watermark,
  input  wire hello_pkg::cnt_t      cnt_value,
  input  wire logic                 cnt_ge_watermark,
  input  wire hello_pkg::led_t      vled_shadow
);

  // Address decode of the current write beat
  logic wr_hello;
  logic wr_ctrl;
  logic wr_load;
  logic wr_wmark;

  assign wr_hello = reg_wr_en && (reg_wr_addr == hello_pkg::HELLO_WORLD_ADDR);
  assign wr_ctrl  = reg_wr_en && (reg_wr_addr == hello_pkg::CNT_CTRL_ADDR);
  assign wr_load  = reg_wr_en && (reg_wr_addr == hello_pkg::CNT_LOAD_ADDR);
  assign wr_wmark = reg_wr_en && (reg_wr_addr == hello_pkg::CNT_WMARK_ADDR);

  // ------------------------------------------------------------
  // Stored registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_world    <= '0;
      cnt_enable     <= 1'b0;
      cnt_oneshot    <= 1'b0;
      tick_limit     <= '0;
      cnt_load_value <= '0;
      cnt_watermark  <= '0;
    end else begin
      if (wr_hello) hello_world <= reg_wr_data;
      if (wr_ctrl) begin
        cnt_enable  <= reg_wr_data[0];
        cnt_oneshot <= reg_wr_data[1];
        tick_limit  <= reg_wr_data[15:8];
      end
      if (wr_load) cnt_load_value <= reg_wr_data[15:0];
      if (wr_wmark) cnt_watermark <= reg_wr_data[15:0];
    end
  end

  // Load and clear pulses, high for the cycle after the write
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_load  <= 1'b0;
      cnt_clear <= 1'b0;
    end else begin
      cnt_load  <= wr_load;
      cnt_clear <= wr_ctrl && reg_wr_data[2];
    end
  end

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  always_comb begin
    case (reg_rd_addr)
      // Bytes come back in reverse order
      hello_pkg::HELLO_WORLD_ADDR:
        reg_rd_data = {hello_world[7:0], hello_world[15:8],
                       hello_world[23:16], hello_world[31:24]};
      hello_pkg::VLED_ADDR:
        reg_rd_data = {16'h0000, vled_shadow};
      // Clear is a pulse, reads back as 0
      hello_pkg::CNT_CTRL_ADDR:
        reg_rd_data = {16'h0000, tick_limit, 5'b00000, 1'b0, cnt_oneshot, cnt_enable};
      hello_pkg::CNT_STATUS_ADDR:
        reg_rd_data = {15'h0000, cnt_ge_watermark, cnt_value};
      default:
        reg_rd_data = hello_pkg::UNIMPLEMENTED_VALUE;
    endcase
  end

endmodule

`default_nettype wire

/* src/hello_top.sv */
// OCL register side of hello world only; reset must already be synchronous to clk_main_a0
`default_nettype none
`timescale 1ns/1ps

module hello_top #(
  parameter int SYNC_STAGES = 2
) (
  input  wire logic                 clk_main_a0,
  input  wire logic                 rst_main_n_sync,
  input  wire logic                 ocl_awvalid,
  input  wire hello_pkg::ocl_addr_t ocl_awaddr,
  output logic                      ocl_awready,
  input  wire logic                 ocl_wvalid,
  input  wire hello_pkg::ocl_data_t ocl_wdata,
  input  wire logic [3:0]           ocl_wstrb,
  output logic                      ocl_wready,
  output logic                      ocl_bvalid,
  output hello_pkg::ocl_resp_t      ocl_bresp,
  input  wire logic                 ocl_bready,
  input  wire logic                 ocl_arvalid,
  input  wire hello_pkg::ocl_addr_t ocl_araddr,
  output logic                      ocl_arready,
  output logic                      ocl_rvalid,
  output hello_pkg::ocl_data_t      ocl_rdata,
  output hello_pkg::ocl_resp_t      ocl_rresp,
  input  wire logic                 ocl_rready,
  input  wire hello_pkg::led_t      status_vdip,
  output hello_pkg::led_t           status_vled
);

  // ------------------------------------------------------------
  // Internal nets
  // ------------------------------------------------------------
  logic                 reg_wr_en;
  hello_pkg::ocl_addr_t reg_wr_addr;
  hello_pkg::ocl_data_t reg_wr_data;
  hello_pkg::ocl_addr_t reg_rd_addr;
  hello_pkg::ocl_data_t reg_rd_data;
  hello_pkg::ocl_data_t hello_world;
  hello_pkg::led_t      vled_shadow;

  // Counter control and status
  logic                 cnt_enable;
  logic                 cnt_oneshot;
  hello_pkg::tick_t     tick_limit;
  logic                 cnt_load;
  hello_pkg::cnt_t      cnt_load_value;
  logic                 cnt_clear;
  hello_pkg::cnt_t      cnt_watermark;
  hello_pkg::cnt_t      cnt_value;
  logic                 cnt_ge_watermark;

  // Bus side
  ocl_slave i_slave (
    .clk_main_a0, .rst_main_n_sync,
    .ocl_awvalid, .ocl_awaddr, .ocl_awready,
    .ocl_wvalid, .ocl_wdata, .ocl_wstrb, .ocl_wready,
    .ocl_bvalid, .ocl_bresp, .ocl_bready,
    .ocl_arvalid, .ocl_araddr, .ocl_arready,
    .ocl_rvalid, .ocl_rdata, .ocl_rresp, .ocl_rready,
    .reg_wr_en, .reg_wr_addr, .reg_wr_data, .reg_rd_addr, .reg_rd_data
  );

  hello_regs i_regs (
    .clk_main_a0, .rst_main_n_sync,
    .reg_wr_en, .reg_wr_addr, .reg_wr_data, .reg_rd_addr, .reg_rd_data,
    .hello_world, .cnt_enable, .cnt_oneshot, .tick_limit,
    .cnt_load, .cnt_load_value, .cnt_clear, .cnt_watermark,
    .cnt_value, .cnt_ge_watermark, .vled_shadow
  );

  tick_counter i_counter (
    .clk_main_a0, .rst_main_n_sync,
    .cnt_enable, .cnt_oneshot, .tick_limit,
    .cnt_load, .cnt_load_value, .cnt_clear, .cnt_watermark,
    .cnt_value, .cnt_ge_watermark
  );

  // LED path
  vled_mask #(
    .SYNC_STAGES(SYNC_STAGES)
  ) i_vled (
    .clk_main_a0, .rst_main_n_sync,
    .hello_world, .status_vdip, .vled_shadow, .status_vled
  );

endmodule

`default_nettype wire

/* src/ocl_slave.sv */
// Single-beat AXI-Lite slave only; one write and one read in flight, strobes ignored, always OKAY
`default_nettype none
`timescale 1ns/1ps

module ocl_slave (
  input  wire logic                clk_main_a0,
  input  wire logic                rst_main_n_sync,
  input  wire logic                ocl_awvalid,
  input  wire hello_pkg::ocl_addr_t ocl_awaddr,
  output logic                     ocl_awready,
  input  wire logic                ocl_wvalid,
  input  wire hello_pkg::ocl_data_t ocl_wdata,
  input  wire logic [3:0]          ocl_wstrb,
  output logic                     ocl_wready,
  output logic                     ocl_bvalid,
  output hello_pkg::ocl_resp_t     ocl_bresp,
  input  wire logic                ocl_bready,
  input  wire logic                ocl_arvalid,
  input  wire hello_pkg::ocl_addr_t ocl_araddr,
  output logic                     ocl_arready,
  output logic                     ocl_rvalid,
  output hello_pkg::ocl_data_t     ocl_rdata,
  output hello_pkg::ocl_resp_t     ocl_rresp,
  input  wire logic                ocl_rready,
  output logic                     reg_wr_en,
  output hello_pkg::ocl_addr_t     reg_wr_addr,
  output hello_pkg::ocl_data_t     reg_wr_data,
  output hello_pkg::ocl_addr_t     reg_rd_addr,
  input  wire hello_pkg::ocl_data_t reg_rd_data
);

  hello_pkg::wr_state_t wr_state;
  hello_pkg::rd_state_t rd_state;

  // ------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------
  // Address accepted only when idle
  assign ocl_awready = (wr_state == hello_pkg::WR_IDLE);
  // Data beat accepted as soon as it shows up
  assign ocl_wready  = (wr_state == hello_pkg::WR_DATA) && ocl_wvalid;
  assign ocl_bvalid  = (wr_state == hello_pkg::WR_RESP);
  assign ocl_bresp   = hello_pkg::OCL_RESP_OKAY;

  // Strobe on the data beat itself
  // ocl_wstrb not looked at, full word always written
  assign reg_wr_en   = ocl_wready;
  assign reg_wr_data = ocl_wdata;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= hello_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        hello_pkg::WR_IDLE: if (ocl_awvalid) wr_state <= hello_pkg::WR_DATA;
        hello_pkg::WR_DATA: if (ocl_wvalid) wr_state <= hello_pkg::WR_RESP;
        hello_pkg::WR_RESP: if (ocl_bready) wr_state <= hello_pkg::WR_IDLE;
        default:            wr_state <= hello_pkg::WR_IDLE;
      endcase
    end
  end

  // Address held until the next accept
  always_ff @(posedge clk_main_a0) begin
    if (ocl_awvalid && ocl_awready) begin
      reg_wr_addr <= ocl_awaddr;
    end
  end

  // ------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------
  assign ocl_arready = (rd_state == hello_pkg::RD_IDLE);
  assign ocl_rvalid  = (rd_state == hello_pkg::RD_RESP);
  assign ocl_rresp   = hello_pkg::OCL_RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= hello_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        hello_pkg::RD_IDLE:   if (ocl_arvalid) rd_state <= hello_pkg::RD_LOOKUP;
        // Single lookup cycle
        hello_pkg::RD_LOOKUP: rd_state <= hello_pkg::RD_RESP;
        hello_pkg::RD_RESP:   if (ocl_rready) rd_state <= hello_pkg::RD_IDLE;
        default:              rd_state <= hello_pkg::RD_IDLE;
      endcase
    end
  end

  // Request captured on accept only, data at end of lookup
  always_ff @(posedge clk_main_a0) begin
    if (ocl_arvalid && ocl_arready) begin
      reg_rd_addr <= ocl_araddr;
    end
    if (rd_state == hello_pkg::RD_LOOKUP) begin
      ocl_rdata <= reg_rd_data;
    end
  end

  // ------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------
  a_bvalid_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_bvalid && !ocl_bready |=> ocl_bvalid);

  a_rdata_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_rvalid && !ocl_rready |=> $stable(ocl_rdata));

endmodule

`default_nettype wire

/* src/tick_counter.sv */
// Clear beats load beats counting; oneshot holds the count at 0xFFFF, flag lags the count by 1 cycle
`default_nettype none
`timescale 1ns/1ps

module tick_counter (
  input  wire logic             clk_main_a0,
  input  wire logic             rst_main_n_sync,
  input  wire logic             cnt_enable,
  input  wire logic             cnt_oneshot,
  input  wire hello_pkg::tick_t tick_limit,
  input  wire logic             cnt_load,
  input  wire hello_pkg::cnt_t  cnt_load_value,
  input  wire logic             cnt_clear,
  input  wire hello_pkg::cnt_t  cnt_watermark,
  output hello_pkg::cnt_t       cnt_value,
  output logic                  cnt_ge_watermark
);

  localparam hello_pkg::cnt_t CNT_MAX = '1;

  hello_pkg::tick_t tick_cnt;
  logic             tick;

  // Prescaler wraps here, main count steps once
  assign tick = (tick_cnt >= tick_limit);

  // ------------------------------------------------------------
  // Prescaler and main count
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync || cnt_clear) begin
      tick_cnt  <= '0;
      cnt_value <= '0;
    end else if (cnt_load) begin
      cnt_value <= cnt_load_value;
    end else if (cnt_enable) begin
      if (tick) begin
        tick_cnt <= '0;
        // Saturate in oneshot, wrap otherwise
        if (!(cnt_oneshot && cnt_value == CNT_MAX)) begin
          cnt_value <= cnt_value + 1'b1;
        end
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // Registered watermark compare
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_ge_watermark <= 1'b0;
    end else begin
      cnt_ge_watermark <= (cnt_value >= cnt_watermark);
    end
  end

  // No wrap out of saturation unless clear or load
  a_oneshot_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    cnt_oneshot && cnt_value == CNT_MAX && !cnt_clear && !cnt_load |=> cnt_value == CNT_MAX);

endmodule

`default_nettype wire

/* src/vled_mask.sv */
// DIP inputs are async and pass SYNC_STAGES flops; LED output is registered and reads 0 out of reset
`default_nettype none
`timescale 1ns/1ps

module vled_mask #(
  parameter int SYNC_STAGES = 2
) (
  input  wire logic                 clk_main_a0,
  input  wire logic                 rst_main_n_sync,
  input  wire hello_pkg::ocl_data_t hello_world,
  input  wire hello_pkg::led_t      status_vdip,
  output hello_pkg::led_t           vled_shadow,
  output hello_pkg::led_t           status_vled
);

  // DIP synchronizer chain, last stage is safe to use
  hello_pkg::led_t vdip_sync [SYNC_STAGES];

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        vdip_sync[i] <= '0;
      end
      vled_shadow <= '0;
      status_vled <= '0;
    end else begin
      vdip_sync[0] <= status_vdip;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        vdip_sync[i] <= vdip_sync[i-1];
      end
      // Shadow of the low hello-world half
      vled_shadow <= hello_world[15:0];
      // Switches gate the LEDs
      status_vled <= vled_shadow & vdip_sync[SYNC_STAGES-1];
    end
  end

endmodule

`default_nettype wire
